// File: src.f
logic/arcade_pkg.sv
logic/key_decoder.sv
logic/control_mapper.sv
logic/host_regs.sv
logic/arcade_input_top.sv
dv/clock_gen.sv
dv/input_assert.sv
dv/input_tb.sv

// File: dv/input_stimulus.txt
# op a b c, hex: K pressed code | J joy0 joy1 | W addr data resp | R addr data resp
# C expected ctrl | O expected video_opts, resp 0 is okay and 2 is slverr
C 000
O 0
K 1 75
C 100
K 1 29
C 110
K 0 75
C 010
K 0 29
C 000
K 1 72
K 1 6b
K 1 74
C 0e0
K 0 72
K 0 6b
K 0 74
C 000
K 1 76
K 1 05
K 1 06
K 1 11
K 1 14
C 00f
K 1 3a
C 00f
R 08 0000003a 0
K 0 76
K 0 05
K 0 06
K 0 11
K 0 14
C 000
J 01 00
C 020
J 00 18
K 1 6b
C 150
W 00 00000004 0
O 8
C 0d0
R 04 000000d0 0
K 0 6b
J 00 00
C 000
W 00 0000003c 0
O f
R 00 0000003c 0
W 10 00000000 2
W 04 00000000 2
R 0c 00000000 2
O f
W 00 00000070 0
O 5
R 00 00000030 0
W 00 00000000 0
O 0

// File: dv/input_tb.sv
`default_nettype none

module input_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_JOY = 2;

	logic                               clk_mist;
	logic                               reset;
	logic                               key_strobe;
	logic                               key_pressed;
	logic [7:0]                         key_code;
	arcade_pkg::joy_t [NUM_JOY-1:0]     joy;
	arcade_pkg::axil_req_t              axil_req;
	arcade_pkg::axil_rsp_t              axil_rsp;
	arcade_pkg::player_ctrl_t           ctrl;
	arcade_pkg::video_opts_t            video_opts;
	logic                               core_reset;
	logic [31:0]                        lfsr_state = 32'h2358;
	string                              ops[$];

	clock_gen u_clock_gen (
		.clk_mist (clk_mist),
		.reset    (reset)
	);

	arcade_input_top #(
		.NUM_JOY (NUM_JOY)
	) u_arcade_input_top (
		.clk_mist    (clk_mist),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joy         (joy),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.ctrl        (ctrl),
		.video_opts  (video_opts),
		.core_reset  (core_reset)
	);

	bind host_regs input_assert u_input_assert (
		.clk_mist (clk_mist),
		.reset    (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp)
	);

	// galois taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
		$display("TESTBENCH FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_ctrl(input arcade_pkg::player_ctrl_t exp);
		if (ctrl !== exp) report_mismatch("ctrl", exp, ctrl);
	endtask

	task automatic check_opts(input arcade_pkg::video_opts_t exp);
		if (video_opts !== exp) report_mismatch("video_opts", exp, video_opts);
	endtask

	task automatic check_resp(input string name, input arcade_pkg::axi_resp_e exp,
			input arcade_pkg::axi_resp_e act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask

	task automatic check_data(input logic [31:0] exp);
		if (axil_rsp.r_data !== exp) report_mismatch("r_data", exp, axil_rsp.r_data);
	endtask

	task automatic check_reset(input logic exp);
		if (core_reset !== exp) report_mismatch("core_reset", exp, core_reset);
	endtask

	task automatic next_edge();
		@(posedge clk_mist);
		#1;
	endtask

	// 0 to 3 cycles from two lfsr bits
	task automatic random_stall();
		int n;
		n = 0;
		for (int i = 0; i < 2; i++) begin
			n = (n << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		repeat (n) next_edge();
	endtask

	task automatic key_event(input logic pressed, input logic [7:0] code);
		key_strobe  = 1'b1;
		key_pressed = pressed;
		key_code    = code;
		next_edge();
		key_strobe  = 1'b0;
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input arcade_pkg::axi_resp_e exp_resp);
		axil_req.aw_addr  = addr;
		axil_req.w_data   = data;
		axil_req.aw_valid = 1'b1;
		axil_req.w_valid  = 1'b1;
		do next_edge(); while (!axil_rsp.aw_ready);
		next_edge(); // handshake edge
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid  = 1'b0;
		check_reset(exp_resp == arcade_pkg::resp_okay &&
			data[arcade_pkg::OPT_SOFT_RESET_BIT]);
		next_edge();
		check_reset(1'b0); // pulse lasts one cycle only
		while (!axil_rsp.b_valid) next_edge();
		check_resp("b_resp", exp_resp, axil_rsp.b_resp);
		random_stall();
		axil_req.b_ready = 1'b1;
		next_edge();
		axil_req.b_ready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, input logic [31:0] exp_data,
			input arcade_pkg::axi_resp_e exp_resp);
		axil_req.ar_addr  = addr;
		axil_req.ar_valid = 1'b1;
		do next_edge(); while (!axil_rsp.ar_ready);
		next_edge();
		axil_req.ar_valid = 1'b0;
		while (!axil_rsp.r_valid) next_edge();
		check_data(exp_data);
		check_resp("r_resp", exp_resp, axil_rsp.r_resp);
		random_stall();
		axil_req.r_ready = 1'b1;
		next_edge();
		axil_req.r_ready = 1'b0;
	endtask

	task automatic run_watchdog(input int n_ops);
		repeat (200 * n_ops + 8) @(posedge clk_mist);
		$display("Watchdog expired: the run hung before all stimulus lines completed");
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	endtask

	// bound checker counts assertion failures
	initial begin : assertion_watch
		wait (u_arcade_input_top.u_host_regs.u_input_assert.error_count != 0);
		$display("AXI4-Lite assertion failed at %0t ns", $time);
		$display("TESTBENCH FAILED");
		$fatal(1, "assertion failure");
	end

	initial begin : stimulus_run
		int          fd;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joy         = '0;
		axil_req    = '0;
		fd = $fopen("dv/input_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file dv/input_stimulus.txt");
			$display("TESTBENCH FAILED");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
				ops.push_back(line);
		end
		$fclose(fd);
		fork
			run_watchdog(ops.size());
		join_none
		repeat (2) next_edge();
		check_reset(1'b1); // board reset reaches core_reset
		wait (reset == 1'b0);
		next_edge();
		check_reset(1'b0);
		foreach (ops[i]) begin
			a = '0;
			b = '0;
			c = '0;
			void'($sscanf(ops[i], "%c %h %h %h", op, a, b, c));
			case (op)
				"K": key_event(a[0], b[7:0]);
				"J": begin
					joy[0] = arcade_pkg::joy_t'(a[7:0]);
					joy[1] = arcade_pkg::joy_t'(b[7:0]);
				end
				"W": axi_write(a[7:0], b, arcade_pkg::axi_resp_e'(c[1:0]));
				"R": axi_read(a[7:0], b, arcade_pkg::axi_resp_e'(c[1:0]));
				"C": begin
					next_edge(); // mapper output is registered
					check_ctrl(arcade_pkg::player_ctrl_t'(a[8:0]));
				end
				"O": check_opts(arcade_pkg::video_opts_t'(a[3:0]));
				default: begin
					$display("Unknown operation in stimulus line: %s", ops[i]);
					$display("TESTBENCH FAILED");
					$fatal(1, "bad stimulus");
				end
			endcase
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/input_assert.sv
`default_nettype none

module input_assert (
	input wire                        clk_mist,
	input wire                        reset,
	input wire arcade_pkg::axil_req_t axil_req,
	input wire arcade_pkg::axil_rsp_t axil_rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	int error_count = 0;

	b_resp_held: assert property (@(posedge clk_mist) disable iff (reset)
		axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid && $stable(axil_rsp.b_resp))
	else begin
		$error("write response changed while bready was low");
		error_count++;
	end

	r_data_held: assert property (@(posedge clk_mist) disable iff (reset)
		axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data))
	else begin
		$error("read data changed while rready was low");
		error_count++;
	end

	aw_w_together: assert property (@(posedge clk_mist) disable iff (reset)
		$rose(axil_rsp.aw_ready) == $rose(axil_rsp.w_ready))
	else begin
		$error("awready and wready did not rise together");
		error_count++;
	end

	// sync reset so readies are low from the edge after
	ready_low_in_reset: assert property (@(posedge clk_mist)
		reset |=> !(axil_rsp.aw_ready || axil_rsp.w_ready || axil_rsp.ar_ready))
	else begin
		$error("ready output high during reset");
		error_count++;
	end

endmodule

`default_nettype wire

// File: dv/clock_gen.sv
`default_nettype none

module clock_gen (
	output logic clk_mist,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_mist = 1'b0;
		forever #20 clk_mist = ~clk_mist; // 40 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk_mist);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/arcade_input_top.sv
`default_nettype none

module arcade_input_top #(
	parameter int NUM_JOY = 2
) (
	input  wire                            clk_mist,
	input  wire                            reset,
	input  wire                            key_strobe,
	input  wire                            key_pressed,
	input  wire [7:0]                      key_code,
	input  arcade_pkg::joy_t [NUM_JOY-1:0] joy,
	input  arcade_pkg::axil_req_t          axil_req,
	output arcade_pkg::axil_rsp_t          axil_rsp,
	output arcade_pkg::player_ctrl_t       ctrl,
	output arcade_pkg::video_opts_t        video_opts,
	output wire                            core_reset
);

	arcade_pkg::key_buttons_t buttons;
	logic [7:0]               last_key;

	key_decoder u_key_decoder (
		.clk_mist    (clk_mist),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (buttons),
		.last_key    (last_key)
	);

	control_mapper #(
		.NUM_JOY (NUM_JOY)
	) u_control_mapper (
		.clk_mist (clk_mist),
		.reset    (reset),
		.buttons  (buttons),
		.joy      (joy),
		.rotate   (video_opts.rotate), // from option word
		.ctrl     (ctrl)
	);

	host_regs u_host_regs (
		.clk_mist   (clk_mist),
		.reset      (reset),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.ctrl       (ctrl),
		.last_key   (last_key),
		.video_opts (video_opts),
		.core_reset (core_reset)
	);

endmodule

`default_nettype wire

// File: logic/host_regs.sv
`default_nettype none

module host_regs (
	input  wire                      clk_mist,
	input  wire                      reset,
	input  arcade_pkg::axil_req_t    axil_req,
	output arcade_pkg::axil_rsp_t    axil_rsp,
	input  arcade_pkg::player_ctrl_t ctrl,
	input  wire [7:0]                last_key,
	output arcade_pkg::video_opts_t  video_opts,
	output logic                     core_reset
);

	typedef enum logic [1:0] {
		st_idle,
		st_write_resp,
		st_read_resp
	} state_e;

	state_e                state;
	logic                  aw_ready;
	logic                  w_ready;
	logic                  ar_ready;
	logic                  b_valid;
	logic                  r_valid;
	arcade_pkg::axi_resp_e b_resp;
	arcade_pkg::axi_resp_e r_resp;
	logic [31:0]           r_data;
	logic                  soft_pulse;
	logic [31:0]           rd_data;
	arcade_pkg::axi_resp_e rd_resp;
	logic                  wr_hit;

	assign wr_hit = (axil_req.aw_addr == arcade_pkg::REG_OPTIONS);

	// read mux, bad offsets return zero
	always_comb begin
		rd_data = '0;
		rd_resp = arcade_pkg::resp_okay;
		case (axil_req.ar_addr)
			arcade_pkg::REG_OPTIONS: begin
				rd_data[arcade_pkg::OPT_ROTATE_BIT] = video_opts.rotate;
				rd_data[arcade_pkg::OPT_SCAN_HI:arcade_pkg::OPT_SCAN_LO] = video_opts.scanlines;
				rd_data[arcade_pkg::OPT_OVERLAY_BIT] = video_opts.overlay_off;
			end
			arcade_pkg::REG_CONTROLS: rd_data[8:0] = ctrl;
			arcade_pkg::REG_LAST_KEY: rd_data[7:0] = last_key;
			default: rd_resp = arcade_pkg::resp_slverr;
		endcase
	end

	always_ff @(posedge clk_mist) begin
		if (reset) begin
			state      <= st_idle;
			aw_ready   <= 1'b0;
			w_ready    <= 1'b0;
			ar_ready   <= 1'b0;
			b_valid    <= 1'b0;
			r_valid    <= 1'b0;
			video_opts <= '0;
			soft_pulse <= 1'b0;
		end else begin
			soft_pulse <= 1'b0;
			case (state)
				st_idle: begin
					if (aw_ready) begin // write handshake this edge
						aw_ready <= 1'b0;
						w_ready  <= 1'b0;
						b_valid  <= 1'b1;
						state    <= st_write_resp;
						if (wr_hit) begin
							video_opts.rotate <= axil_req.w_data[arcade_pkg::OPT_ROTATE_BIT];
							video_opts.scanlines <=
								axil_req.w_data[arcade_pkg::OPT_SCAN_HI:arcade_pkg::OPT_SCAN_LO];
							video_opts.overlay_off <=
								axil_req.w_data[arcade_pkg::OPT_OVERLAY_BIT];
							soft_pulse <= axil_req.w_data[arcade_pkg::OPT_SOFT_RESET_BIT];
						end
					end else if (ar_ready) begin
						ar_ready <= 1'b0;
						r_valid  <= 1'b1;
						state    <= st_read_resp;
					end else if (axil_req.aw_valid && axil_req.w_valid) begin
						aw_ready <= 1'b1; // write wins over read
						w_ready  <= 1'b1;
					end else if (axil_req.ar_valid) begin
						ar_ready <= 1'b1;
					end
				end
				st_write_resp: begin
					if (axil_req.b_ready) begin
						b_valid <= 1'b0;
						state   <= st_idle;
					end
				end
				st_read_resp: begin
					if (axil_req.r_ready) begin
						r_valid <= 1'b0;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// response payload, loaded only on a handshake
	always_ff @(posedge clk_mist) begin
		if (state == st_idle && aw_ready) begin
			b_resp <= wr_hit ? arcade_pkg::resp_okay : arcade_pkg::resp_slverr;
		end
		if (state == st_idle && !aw_ready && ar_ready) begin
			r_data <= rd_data;
			r_resp <= rd_resp;
		end
	end

	assign axil_rsp.aw_ready = aw_ready;
	assign axil_rsp.w_ready  = w_ready;
	assign axil_rsp.b_valid  = b_valid;
	assign axil_rsp.b_resp   = b_resp;
	assign axil_rsp.ar_ready = ar_ready;
	assign axil_rsp.r_valid  = r_valid;
	assign axil_rsp.r_data   = r_data;
	assign axil_rsp.r_resp   = r_resp;

	assign core_reset = reset | soft_pulse; // osd reset toggle or board reset

endmodule

`default_nettype wire

// File: logic/control_mapper.sv
`default_nettype none

module control_mapper #(
	parameter int NUM_JOY = 2
) (
	input  wire                                     clk_mist,
	input  wire                                     reset,
	input  arcade_pkg::key_buttons_t                buttons,
	input  arcade_pkg::joy_t [NUM_JOY-1:0]          joy,
	input  wire                                     rotate,
	output arcade_pkg::player_ctrl_t                ctrl
);

	logic j_up;
	logic j_down;
	logic j_left;
	logic j_right;
	logic j_fire1;
	logic j_fire2;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	arcade_pkg::player_ctrl_t ctrl_next;

	// or of every joystick port
	always_comb begin
		j_up    = 1'b0;
		j_down  = 1'b0;
		j_left  = 1'b0;
		j_right = 1'b0;
		j_fire1 = 1'b0;
		j_fire2 = 1'b0;
		for (int i = 0; i < NUM_JOY; i++) begin
			j_up    = j_up    | joy[i].up;
			j_down  = j_down  | joy[i].down;
			j_left  = j_left  | joy[i].left;
			j_right = j_right | joy[i].right;
			j_fire1 = j_fire1 | joy[i].fire1;
			j_fire2 = j_fire2 | joy[i].fire2;
		end
	end

	assign m_up    = buttons.up    | j_up;
	assign m_down  = buttons.down  | j_down;
	assign m_left  = buttons.left  | j_left;
	assign m_right = buttons.right | j_right;

	always_comb begin
		if (rotate) begin // cabinet on its side
			ctrl_next.up    = m_right;
			ctrl_next.down  = m_left;
			ctrl_next.left  = m_up;
			ctrl_next.right = m_down;
		end else begin
			ctrl_next.up    = m_up;
			ctrl_next.down  = m_down;
			ctrl_next.left  = m_left;
			ctrl_next.right = m_right;
		end
		ctrl_next.fire   = buttons.fire1 | j_fire1;
		ctrl_next.bomb   = buttons.fire2 | j_fire2;
		ctrl_next.coin   = buttons.coin; // keyboard only
		ctrl_next.start1 = buttons.start1;
		ctrl_next.start2 = buttons.start2;
	end

	always_ff @(posedge clk_mist) begin
		if (reset) begin
			ctrl <= '0;
		end else begin
			ctrl <= ctrl_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/key_decoder.sv
`default_nettype none

module key_decoder (
	input  wire                     clk_mist,
	input  wire                     reset,
	input  wire                     key_strobe,
	input  wire                     key_pressed,
	input  wire [7:0]               key_code,
	output arcade_pkg::key_buttons_t buttons,
	output logic [7:0]              last_key
);

	always_ff @(posedge clk_mist) begin
		if (reset) begin
			buttons  <= '0;
			last_key <= '0;
		end else if (key_strobe) begin
			last_key <= key_code; // kept even when not recognised
			case (key_code)
				arcade_pkg::key_up:    buttons.up     <= key_pressed;
				arcade_pkg::key_down:  buttons.down   <= key_pressed;
				arcade_pkg::key_left:  buttons.left   <= key_pressed;
				arcade_pkg::key_right: buttons.right  <= key_pressed;
				arcade_pkg::key_esc:   buttons.coin   <= key_pressed;
				arcade_pkg::key_f1:    buttons.start1 <= key_pressed;
				arcade_pkg::key_f2:    buttons.start2 <= key_pressed;
				arcade_pkg::key_ctrl:  buttons.fire3  <= key_pressed;
				arcade_pkg::key_alt:   buttons.fire2  <= key_pressed;
				arcade_pkg::key_space: buttons.fire1  <= key_pressed;
				default: ; // other keys ignored
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/arcade_pkg.sv
`default_nettype none

package arcade_pkg;

	// ps/2 set 2 codes as sent by the io controller
	typedef enum logic [7:0] {
		key_up    = 8'h75,
		key_down  = 8'h72,
		key_left  = 8'h6b,
		key_right = 8'h74,
		key_esc   = 8'h76, // coin
		key_f1    = 8'h05, // 1 player
		key_f2    = 8'h06, // 2 players
		key_ctrl  = 8'h14,
		key_alt   = 8'h11,
		key_space = 8'h29
	} key_code_e;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_e;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} key_buttons_t;

	// bit 0 is right, same order as the io controller
	typedef struct packed {
		logic [1:0] spare;
		logic       fire2;
		logic       fire1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic coin;
		logic start1;
		logic start2;
	} player_ctrl_t;

	typedef struct packed {
		logic       rotate;
		logic [1:0] scanlines;
		logic       overlay_off;
	} video_opts_t;

	typedef struct packed {
		logic [7:0]  aw_addr;
		logic        aw_valid;
		logic [31:0] w_data;
		logic        w_valid;
		logic        b_ready;
		logic [7:0]  ar_addr;
		logic        ar_valid;
		logic        r_ready;
	} axil_req_t;

	typedef struct packed {
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		axi_resp_e   b_resp;
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		axi_resp_e   r_resp;
	} axil_rsp_t;

	localparam logic [7:0] REG_OPTIONS  = 8'h00;
	localparam logic [7:0] REG_CONTROLS = 8'h04; // read only
	localparam logic [7:0] REG_LAST_KEY = 8'h08; // read only

	// option word layout, matches the osd status bits
	localparam int OPT_ROTATE_BIT     = 2;
	localparam int OPT_SCAN_LO        = 3;
	localparam int OPT_SCAN_HI        = 4;
	localparam int OPT_OVERLAY_BIT    = 5;
	localparam int OPT_SOFT_RESET_BIT = 6;

endpackage

`default_nettype wire
